// File: dv/ifetch_tb.sv
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module ifetch_tb;

  localparam int MAX_LINES = 64;
  localparam logic [31:0] MEM_KEY = 32'h1357_9bdf;

  logic                   clk_i, arst_n_i;
  logic [`IF_ADDR_W-1:0]  vaddr_i;
  logic                   vaddr_v_i, vaddr_ready_o;
  logic [`IF_PTAG_W-1:0]  ptag_i;
  logic                   uncached_i;
  logic [`IF_INSTR_W-1:0] data_o;
  logic                   data_v_o;
  logic [`IF_ADDR_W-1:0]  mem_cmd_addr_o;
  logic                   mem_cmd_uncached_o, mem_cmd_v_o, mem_cmd_ready_i;
  logic [`IF_LINE_W-1:0]  mem_resp_data_i;
  logic                   mem_resp_v_i, mem_resp_yumi_o;

  logic [31:0] trace_mem [0:MAX_LINES*4-1];
  logic [31:0] exp_cmd_addr [$];
  logic        exp_cmd_unc [$];
  logic [31:0] hold_addr, resp_addr;
  logic        cmd_hold, resp_unc;
  integer      seed;
  int n_lines = 0;
  int send_idx, recv_idx, resp_wait;
  int data_errors, cmd_errors, proto_errors;

  ifetch_top i_dut (
    .clk_i, .arst_n_i, .vaddr_i, .vaddr_v_i, .vaddr_ready_o, .ptag_i, .uncached_i,
    .data_o, .data_v_o, .mem_cmd_addr_o, .mem_cmd_uncached_o, .mem_cmd_v_o,
    .mem_cmd_ready_i, .mem_resp_data_i, .mem_resp_v_i, .mem_resp_yumi_o
  );

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return a ^ MEM_KEY;
  endfunction

  function automatic logic [`IF_LINE_W-1:0] mem_line(input logic [31:0] a);
    return {mem_word(a + 32'd12), mem_word(a + 32'd8), mem_word(a + 32'd4), mem_word(a)};
  endfunction

  task automatic load_trace();
    for (int i = 0; i < MAX_LINES * 4; i++) begin
      trace_mem[i] = ~i;
    end
    $readmemh("dv/ifetch_trace.txt", trace_mem);
    // Uncached column is 0 or 1 on every real line
    while (n_lines < MAX_LINES && trace_mem[4*n_lines+2] <= 32'd1) begin
      n_lines++;
    end
  endtask

  // Direct mapped tag model plus the one-word uncached buffer
  task automatic predict_commands();
    logic [`IF_PTAG_W-1:0] set_tag [`IF_SETS];
    logic [`IF_SETS-1:0]   set_v;
    logic                  unc_v;
    logic [31:0]           unc_addr, paddr;
    logic [3:0]            idx;
    set_v = '0;
    unc_v = 1'b0;
    for (int i = 0; i < n_lines; i++) begin
      paddr = {trace_mem[4*i+1][`IF_PTAG_W-1:0], trace_mem[4*i][`IF_PAGE_OFS_W-1:0]};
      idx   = paddr[7:4];
      if (trace_mem[4*i+2][0]) begin
        if (!(unc_v && unc_addr == {paddr[31:2], 2'b00})) begin
          exp_cmd_addr.push_back({paddr[31:2], 2'b00});
          exp_cmd_unc.push_back(1'b1);
        end
        unc_v    = 1'b1;
        unc_addr = {paddr[31:2], 2'b00};
      end else if (!(set_v[idx] && set_tag[idx] == paddr[31:12])) begin
        exp_cmd_addr.push_back({paddr[31:4], 4'h0});
        exp_cmd_unc.push_back(1'b0);
        set_v[idx]   = 1'b1;
        set_tag[idx] = paddr[31:12];
      end
    end
  endtask

  task automatic check_reset_state();
    @(negedge clk_i);
    if (data_v_o !== 1'b0 || mem_cmd_v_o !== 1'b0 || mem_resp_yumi_o !== 1'b0) begin
      $display("** Error reset_state: expected 000 actual %b%b%b",
               data_v_o, mem_cmd_v_o, mem_resp_yumi_o);
      proto_errors++;
    end
    if (vaddr_ready_o !== 1'b1) begin
      $display("** Error reset_ready: expected 1 actual %b", vaddr_ready_o);
      proto_errors++;
    end
    @(posedge clk_i);
    #1;
  endtask

  // One clock: drive after the edge, sample at the falling edge
  task automatic run_cycle();
    logic accepted, resp_done, exp_ready;
    vaddr_v_i = (send_idx < n_lines);
    if (send_idx < n_lines) begin
      vaddr_i    = trace_mem[4*send_idx];
      ptag_i     = trace_mem[4*send_idx+1][`IF_PTAG_W-1:0];
      uncached_i = trace_mem[4*send_idx+2][0];
    end
    mem_cmd_ready_i = ({$random(seed)} % 4) != 0;
    if (resp_wait > 0) begin
      resp_wait--;
      if (resp_wait == 0) begin
        mem_resp_v_i    = 1'b1;
        mem_resp_data_i = resp_unc ? {{(`IF_LINE_W-32){1'b0}}, mem_word(resp_addr)}
                                   : mem_line(resp_addr);
      end
    end
    @(negedge clk_i);
    accepted  = vaddr_v_i && vaddr_ready_o;
    resp_done = mem_resp_v_i && mem_resp_yumi_o;
    // Queue is full with eight fetches accepted and not yet returned
    exp_ready = (send_idx - recv_idx) != `IF_QUEUE_DEPTH;
    if (vaddr_ready_o !== exp_ready) begin
      $display("** Error fetch_ready: expected %b actual %b", exp_ready, vaddr_ready_o);
      proto_errors++;
    end
    if (mem_resp_yumi_o !== mem_resp_v_i) begin
      $display("** Error resp_yumi: expected %b actual %b", mem_resp_v_i, mem_resp_yumi_o);
      proto_errors++;
    end
    if (data_v_o) begin
      if (recv_idx >= send_idx) begin
        $display("Instruction returned with no fetch outstanding");
        proto_errors++;
      end else if (data_o !== trace_mem[4*recv_idx+3]) begin
        $display("** Error fetch_data[%0d]: expected %h actual %h",
                 recv_idx, trace_mem[4*recv_idx+3], data_o);
        data_errors++;
      end
      recv_idx++;
    end
    if (mem_cmd_v_o) begin
      if (cmd_hold && mem_cmd_addr_o !== hold_addr) begin
        $display("** Error cmd_hold: expected %h actual %h", hold_addr, mem_cmd_addr_o);
        cmd_errors++;
      end
      if (mem_cmd_ready_i) begin
        if (exp_cmd_addr.size() == 0) begin
          $display("Memory command to %h where the tag model expects none", mem_cmd_addr_o);
          cmd_errors++;
        end else begin
          if (mem_cmd_addr_o !== exp_cmd_addr[0] || mem_cmd_uncached_o !== exp_cmd_unc[0]) begin
            $display("** Error mem_cmd: expected %h/%b actual %h/%b", exp_cmd_addr[0],
                     exp_cmd_unc[0], mem_cmd_addr_o, mem_cmd_uncached_o);
            cmd_errors++;
          end
          void'(exp_cmd_addr.pop_front());
          void'(exp_cmd_unc.pop_front());
        end
        resp_addr = mem_cmd_addr_o;
        resp_unc  = mem_cmd_uncached_o;
        resp_wait = 1 + {$random(seed)} % 6;
      end
      cmd_hold  = !mem_cmd_ready_i;
      hold_addr = mem_cmd_addr_o;
    end else begin
      if (cmd_hold) begin
        $display("Memory command withdrawn before it was accepted");
        proto_errors++;
      end
      cmd_hold = 1'b0;
    end
    @(posedge clk_i);
    #1;
    if (accepted) begin
      send_idx++;
    end
    if (resp_done) begin
      mem_resp_v_i = 1'b0;
    end
  endtask

  initial begin
    clk_i           = 1'b0;
    arst_n_i        = 1'b0;
    vaddr_i         = '0;
    vaddr_v_i       = 1'b0;
    ptag_i          = '0;
    uncached_i      = 1'b0;
    mem_cmd_ready_i = 1'b0;
    mem_resp_data_i = '0;
    mem_resp_v_i    = 1'b0;
    seed            = 32'h5a25;
    cmd_hold        = 1'b0;
    load_trace();
    if (n_lines == 0) begin
      $display("Trace file is missing or holds no fetches");
      proto_errors++;
    end
    predict_commands();
    repeat (4) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    check_reset_state();
    while (recv_idx < n_lines) begin
      run_cycle();
    end
    // Drain to catch stray returns or commands
    repeat (20) run_cycle();
    if (exp_cmd_addr.size() != 0) begin
      $display("%0d expected memory commands were never issued", exp_cmd_addr.size());
      cmd_errors++;
    end
    $display("Errors: data %0d, command %0d, protocol %0d", data_errors, cmd_errors,
             proto_errors);
    if (data_errors + cmd_errors + proto_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (n_lines != 0);
    repeat (200 * n_lines + 100) @(posedge clk_i);
    $display("Timeout with %0d of %0d fetches returned", recv_idx, n_lines);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: dv/ifetch_trace.txt
// Columns: vaddr, ptag, uncached, expected instruction
// Expected instruction is the memory word at {ptag, vaddr[11:0]}
00400000 00080 0 135f9bdf
00400004 00080 0 135f9bdb
00400008 00080 0 135f9bd7
0040000c 00080 0 135f9bd3
00400010 00080 0 135f9bcf
00400014 00080 0 135f9bcb
00400020 00080 0 135f9bff
00400000 00080 0 135f9bdf
00401000 00123 0 1345abdf
00401004 00123 0 1345abdb
00400000 00080 0 135f9bdf
00402040 00a5c 1 13f25b9f
00402040 00a5c 1 13f25b9f
00402040 00a5c 0 13f25b9f
00402048 00a5c 1 13f25b97
00402044 00a5c 0 13f25b9b
004000f0 00080 0 135f9b2f
004000fc 00080 0 135f9b23
00400024 00080 0 135f9bfb
00400014 00080 0 135f9bcb
0040100c 00123 0 1345abd3
00400008 00080 0 135f9bd7

// File: logic/fetch_replay_fifo.sv
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module fetch_replay_fifo
  import ifetch_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic [`IF_ADDR_W-1:0] vaddr_i,
  input  logic [`IF_PTAG_W-1:0] ptag_i,
  input  logic                  uncached_i,
  input  logic                  vaddr_v_i,
  input  logic                  commit_i,
  input  logic                  rollback_i,
  output logic                  vaddr_ready_o,
  fetch_if.queue                fif
);

  fetch_addr_u           vaddr_mem    [`IF_QUEUE_DEPTH];
  logic [`IF_PTAG_W-1:0] ptag_mem     [`IF_QUEUE_DEPTH];
  logic                  uncached_mem [`IF_QUEUE_DEPTH];

  logic [`IF_QUEUE_PTR_W-1:0] wr_ptr, rd_ptr, cm_ptr;
  // Uncommitted and not yet read entry counts
  logic [`IF_QUEUE_PTR_W:0]   count, unread;
  logic [`IF_QUEUE_PTR_W:0]   enq_ext, deq_ext, commit_ext;
  logic                       enq, deq;

  assign vaddr_ready_o = (count != `IF_QUEUE_DEPTH);
  assign enq = vaddr_v_i & vaddr_ready_o;
  assign deq = fif.v & fif.yumi;

  assign enq_ext    = {{`IF_QUEUE_PTR_W{1'b0}}, enq};
  assign deq_ext    = {{`IF_QUEUE_PTR_W{1'b0}}, deq};
  assign commit_ext = {{`IF_QUEUE_PTR_W{1'b0}}, commit_i};

  assign fif.v        = (unread != '0);
  assign fif.vaddr    = vaddr_mem[rd_ptr];
  assign fif.ptag     = ptag_mem[rd_ptr];
  assign fif.uncached = uncached_mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (enq) begin
      vaddr_mem[wr_ptr].raw <= vaddr_i;
      ptag_mem[wr_ptr]      <= ptag_i;
      uncached_mem[wr_ptr]  <= uncached_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cm_ptr <= '0;
      count  <= '0;
      unread <= '0;
    end else begin
      if (enq) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (commit_i) begin
        cm_ptr <= cm_ptr + 1'b1;
      end
      count <= count + enq_ext - commit_ext;
      // Replay from the oldest fetch not yet returned
      if (rollback_i) begin
        rd_ptr <= cm_ptr;
        unread <= count + enq_ext;
      end else begin
        if (deq) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
        unread <= unread + enq_ext - deq_ext;
      end
    end
  end

  // A write never lands on an uncommitted entry
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    enq |-> ((count == '0) || (wr_ptr != cm_ptr)));

  // A commit always matches a fetch that was read out
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    commit_i |-> (count != unread));

endmodule

// File: logic/icache_lookup.sv
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module icache_lookup
  import ifetch_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  busy_i,
  input  logic                  rollback_i,
  fetch_if.stage                fif,
  fill_if.arrays                flif,
  output logic                  tl_v_o,
  output fetch_addr_u           tl_addr_o,
  output logic [`IF_PTAG_W-1:0] tl_ptag_o,
  output logic                  tl_uncached_o,
  output logic [`IF_PTAG_W-1:0] tl_tag_o,
  output logic                  tl_valid_o,
  output logic [`IF_LINE_W-1:0] tl_line_o
);

  logic [`IF_PTAG_W-1:0]  tag_mem  [`IF_SETS];
  logic [`IF_LINE_W-1:0]  line_mem [`IF_SETS];
  logic [`IF_SETS-1:0]    valid_mem;
  logic [`IF_INDEX_W-1:0] rd_index;

  // No dequeue while a miss is pending or being rolled back
  assign fif.yumi = fif.v & ~busy_i & ~rollback_i;
  assign rd_index = fif.vaddr.f.index;

  always_ff @(posedge clk_i) begin
    if (flif.we) begin
      tag_mem[flif.index]  <= flif.tag;
      line_mem[flif.index] <= flif.line;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_mem <= '0;
    end else if (flif.we) begin
      valid_mem[flif.index] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tl_v_o <= 1'b0;
    end else begin
      tl_v_o <= fif.yumi;
    end
  end

  // Array read into the lookup register
  always_ff @(posedge clk_i) begin
    if (fif.yumi) begin
      tl_addr_o     <= fif.vaddr;
      tl_ptag_o     <= fif.ptag;
      tl_uncached_o <= fif.uncached;
      tl_tag_o      <= tag_mem[rd_index];
      tl_valid_o    <= valid_mem[rd_index];
      tl_line_o     <= line_mem[rd_index];
    end
  end

  // Fills only land on an empty front end
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flif.we |-> !fif.yumi);

endmodule

// File: logic/icache_miss_engine.sv
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module icache_miss_engine
  import ifetch_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  mem_cmd_ready_i,
  input  logic [`IF_LINE_W-1:0] mem_resp_data_i,
  input  logic                  mem_resp_v_i,
  miss_if.engine                mif,
  fill_if.writer                flif,
  output logic [`IF_ADDR_W-1:0] mem_cmd_addr_o,
  output logic                  mem_cmd_uncached_o,
  output logic                  mem_cmd_v_o,
  output logic                  mem_resp_yumi_o
);

  miss_state_e            state_r, state_n;
  logic [`IF_ADDR_W-1:0]  cmd_addr_r;
  logic                   uncached_r;
  logic [`IF_LINE_W-1:0]  line_r;
  logic                   unc_v_r;
  logic [`IF_ADDR_W-1:0]  unc_paddr_r;
  logic [`IF_INSTR_W-1:0] unc_word_r;
  logic                   resp_take;

  assign resp_take = (state_r == e_wait_resp) & mem_resp_v_i;

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_idle:      if (mif.req_v) state_n = e_send_cmd;
      e_send_cmd:  if (mem_cmd_ready_i) state_n = e_wait_resp;
      e_wait_resp: if (mem_resp_v_i) state_n = uncached_r ? e_idle : e_fill;
      e_fill:      state_n = e_idle;
      default:     state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r    <= e_idle;
      uncached_r <= 1'b0;
      unc_v_r    <= 1'b0;
    end else begin
      state_r <= state_n;
      if (mif.req_v) begin
        uncached_r <= mif.req_uncached;
      end
      if (resp_take && uncached_r) begin
        unc_v_r <= 1'b1;
      end
    end
  end

  // Uncached reads are word aligned, line fills line aligned
  always_ff @(posedge clk_i) begin
    if (mif.req_v) begin
      cmd_addr_r <= mif.req_uncached
        ? {mif.req_paddr[`IF_ADDR_W-1:`IF_BYTE_OFS_W], {`IF_BYTE_OFS_W{1'b0}}}
        : {mif.req_paddr[`IF_ADDR_W-1:`IF_LINE_OFS_W], {`IF_LINE_OFS_W{1'b0}}};
    end
    if (resp_take && !uncached_r) begin
      line_r <= mem_resp_data_i;
    end
    if (resp_take && uncached_r) begin
      unc_paddr_r <= cmd_addr_r;
      unc_word_r  <= mem_resp_data_i[`IF_INSTR_W-1:0];
    end
  end

  assign mem_cmd_v_o        = (state_r == e_send_cmd);
  assign mem_cmd_addr_o     = cmd_addr_r;
  assign mem_cmd_uncached_o = uncached_r;
  assign mem_resp_yumi_o    = resp_take;

  assign mif.busy      = (state_r != e_idle);
  assign mif.unc_v     = unc_v_r;
  assign mif.unc_paddr = unc_paddr_r;
  assign mif.unc_word  = unc_word_r;

  assign flif.we    = (state_r == e_fill);
  assign flif.index = cmd_addr_r[`IF_LINE_OFS_W +: `IF_INDEX_W];
  assign flif.tag   = cmd_addr_r[`IF_ADDR_W-1 -: `IF_PTAG_W];
  assign flif.line  = line_r;

  // Misses only arrive once the previous one has filled
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mif.req_v |-> (state_r == e_idle));

  // Command held with a stable address until accepted
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (mem_cmd_v_o && !mem_cmd_ready_i) |=> (mem_cmd_v_o && $stable(mem_cmd_addr_o)));

endmodule

// File: logic/icache_verify.sv
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module icache_verify
  import ifetch_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   tl_v_i,
  input  fetch_addr_u            tl_addr_i,
  input  logic [`IF_PTAG_W-1:0]  tl_ptag_i,
  input  logic                   tl_uncached_i,
  input  logic [`IF_PTAG_W-1:0]  tl_tag_i,
  input  logic                   tl_valid_i,
  input  logic [`IF_LINE_W-1:0]  tl_line_i,
  miss_if.verify                 mif,
  output logic [`IF_INSTR_W-1:0] data_o,
  output logic                   data_v_o,
  output logic                   rollback_o
);

  logic [`IF_ADDR_W-1:0]  paddr;
  logic [`IF_ADDR_W-1:0]  paddr_word;
  logic [`IF_INSTR_W-1:0] word;
  logic                   tag_hit, unc_hit, hit, take;
  logic [`IF_ADDR_W-1:0]  paddr_r;
  logic                   uncached_r;

  assign paddr      = {tl_ptag_i, tl_addr_i.raw[`IF_PAGE_OFS_W-1:0]};
  assign paddr_word = {paddr[`IF_ADDR_W-1:`IF_BYTE_OFS_W], {`IF_BYTE_OFS_W{1'b0}}};

  assign tag_hit = tl_valid_i && (tl_tag_i == tl_ptag_i);
  assign unc_hit = mif.unc_v && (mif.unc_paddr == paddr_word);
  assign hit     = tl_uncached_i ? unc_hit : tag_hit;

  assign word = tl_uncached_i ? mif.unc_word
                              : tl_line_i[tl_addr_i.f.word_ofs * `IF_INSTR_W +: `IF_INSTR_W];

  // Poison the younger fetch behind a miss
  assign take = tl_v_i & ~rollback_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_v_o   <= 1'b0;
      rollback_o <= 1'b0;
    end else begin
      data_v_o   <= take & hit;
      rollback_o <= take & ~hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      data_o     <= word;
      paddr_r    <= paddr;
      uncached_r <= tl_uncached_i;
    end
  end

  assign mif.req_v        = rollback_o;
  assign mif.req_paddr    = paddr_r;
  assign mif.req_uncached = uncached_r;

  // No instruction returns while a miss is outstanding
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    data_v_o |-> !mif.busy);

endmodule

// File: logic/ifetch_ifs.sv
`timescale 1ns/1ps
`include "ifetch_macros.svh"

// Replay queue to tag-lookup stage
interface fetch_if
  import ifetch_pkg::*;
  ();
  logic                  v;
  fetch_addr_u           vaddr;
  logic [`IF_PTAG_W-1:0] ptag;
  logic                  uncached;
  logic                  yumi;

  modport queue (output v, vaddr, ptag, uncached, input yumi);
  modport stage (input v, vaddr, ptag, uncached, output yumi);
endinterface

// Miss request and uncached buffer
interface miss_if;
  logic                   req_v;
  logic [`IF_ADDR_W-1:0]  req_paddr;
  logic                   req_uncached;
  logic                   busy;
  logic                   unc_v;
  logic [`IF_ADDR_W-1:0]  unc_paddr;
  logic [`IF_INSTR_W-1:0] unc_word;

  modport verify (output req_v, req_paddr, req_uncached,
                  input busy, unc_v, unc_paddr, unc_word);
  modport engine (input req_v, req_paddr, req_uncached,
                  output busy, unc_v, unc_paddr, unc_word);
endinterface

// Line fill into the arrays
interface fill_if;
  logic                   we;
  logic [`IF_INDEX_W-1:0] index;
  logic [`IF_PTAG_W-1:0]  tag;
  logic [`IF_LINE_W-1:0]  line;

  modport writer (output we, index, tag, line);
  modport arrays (input we, index, tag, line);
endinterface

// File: logic/ifetch_macros.svh
`ifndef IFETCH_MACROS_SVH
`define IFETCH_MACROS_SVH

// Address and physical tag
`define IF_ADDR_W 32
`define IF_PTAG_W 20
`define IF_PAGE_OFS_W (`IF_ADDR_W - `IF_PTAG_W)

// Direct mapped geometry
`define IF_INDEX_W 4
`define IF_SETS 16
`define IF_WORD_OFS_W 2
`define IF_BYTE_OFS_W 2
`define IF_LINE_OFS_W (`IF_WORD_OFS_W + `IF_BYTE_OFS_W)
`define IF_HIGH_W (`IF_ADDR_W - `IF_INDEX_W - `IF_LINE_OFS_W)
`define IF_LINE_W 128
`define IF_INSTR_W 32

// Replay queue
`define IF_QUEUE_DEPTH 8
`define IF_QUEUE_PTR_W 3

`endif

// File: logic/ifetch_pkg.sv
package ifetch_pkg;

  `include "ifetch_macros.svh"

  // Field view of a fetch address
  typedef struct packed {
    logic [`IF_HIGH_W-1:0]     high;
    logic [`IF_INDEX_W-1:0]    index;
    logic [`IF_WORD_OFS_W-1:0] word_ofs;
    logic [`IF_BYTE_OFS_W-1:0] byte_ofs;
  } fetch_fields_t;

  typedef union packed {
    logic [`IF_ADDR_W-1:0] raw;
    fetch_fields_t         f;
  } fetch_addr_u;

  typedef enum logic [1:0] {
    e_idle,
    e_send_cmd,
    e_wait_resp,
    e_fill
  } miss_state_e;

endpackage

// File: logic/ifetch_top.sv
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module ifetch_top
  import ifetch_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic [`IF_ADDR_W-1:0]  vaddr_i,
  input  logic                   vaddr_v_i,
  output logic                   vaddr_ready_o,
  input  logic [`IF_PTAG_W-1:0]  ptag_i,
  input  logic                   uncached_i,
  output logic [`IF_INSTR_W-1:0] data_o,
  output logic                   data_v_o,
  output logic [`IF_ADDR_W-1:0]  mem_cmd_addr_o,
  output logic                   mem_cmd_uncached_o,
  output logic                   mem_cmd_v_o,
  input  logic                   mem_cmd_ready_i,
  input  logic [`IF_LINE_W-1:0]  mem_resp_data_i,
  input  logic                   mem_resp_v_i,
  output logic                   mem_resp_yumi_o
);

  fetch_if fif ();
  miss_if  mif ();
  fill_if  flif ();

  logic                  tl_v, tl_uncached, tl_valid, rollback;
  fetch_addr_u           tl_addr;
  logic [`IF_PTAG_W-1:0] tl_ptag, tl_tag;
  logic [`IF_LINE_W-1:0] tl_line;

  fetch_replay_fifo i_queue (
    .clk_i, .arst_n_i, .vaddr_i, .ptag_i, .uncached_i, .vaddr_v_i,
    .commit_i(data_v_o), .rollback_i(rollback), .vaddr_ready_o, .fif(fif.queue)
  );

  icache_lookup i_lookup (
    .clk_i, .arst_n_i, .busy_i(mif.busy), .rollback_i(rollback),
    .fif(fif.stage), .flif(flif.arrays),
    .tl_v_o(tl_v), .tl_addr_o(tl_addr), .tl_ptag_o(tl_ptag), .tl_uncached_o(tl_uncached),
    .tl_tag_o(tl_tag), .tl_valid_o(tl_valid), .tl_line_o(tl_line)
  );

  icache_verify i_verify (
    .clk_i, .arst_n_i,
    .tl_v_i(tl_v), .tl_addr_i(tl_addr), .tl_ptag_i(tl_ptag), .tl_uncached_i(tl_uncached),
    .tl_tag_i(tl_tag), .tl_valid_i(tl_valid), .tl_line_i(tl_line),
    .mif(mif.verify), .data_o, .data_v_o, .rollback_o(rollback)
  );

  icache_miss_engine i_miss (
    .clk_i, .arst_n_i, .mem_cmd_ready_i, .mem_resp_data_i, .mem_resp_v_i,
    .mif(mif.engine), .flif(flif.writer),
    .mem_cmd_addr_o, .mem_cmd_uncached_o, .mem_cmd_v_o, .mem_resp_yumi_o
  );

endmodule

// File: project.f
+incdir+logic
logic/ifetch_pkg.sv
logic/ifetch_ifs.sv
logic/fetch_replay_fifo.sv
logic/icache_lookup.sv
logic/icache_verify.sv
logic/icache_miss_engine.sv
logic/ifetch_top.sv
dv/ifetch_tb.sv
